//--- files.f
source/siFhPkg.sv
source/histogramBuilder.sv
source/peakDetector.sv
source/thresholdCalculator.sv
source/siFhTop.sv
verification/siFhTb.sv

//--- run.sh
#!/bin/sh
# build and run the histogram testbench with Verilator
# the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module siFhTb -f files.f -o siFhSim \
    && ./obj_dir/siFhSim > sim.log 2>&1
grep -q "^STATUS: PASS$" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
exit 0

//--- verification/siFhTb.sv
`timescale 1ns/10ps

module siFhTb import siFhPkg::*; ();

    // edges from the acqFinish sampling edge to the rise of resultValid
    localparam int ResultLatency = NumBins + 1;

    // longest single wait, in cycles
    localparam int WaitLimit = 200;

    logic    clk;
    logic    reset;
    logic    hitValid;
    logic    hitReady;
    binAddrT hitAddr;
    histSelT hitSelect;
    logic    acqFinish;
    logic    resultValid;
    logic    resultReady;
    binAddrT thMinus;
    binAddrT thPlus;
    binAddrT delta;
    binAddrT peakCh;
    binAddrT peakFh;

    // reference histograms, entry 0 unused
    int chRef [0:NumBins];
    int fhRef [0:NumBins];

    int errorCount;
    int timeoutCount;
    integer seed;

    siFhTop dut0 (
        .clk         (clk),
        .reset       (reset),
        .hitValid    (hitValid),
        .hitReady    (hitReady),
        .hitAddr     (hitAddr),
        .hitSelect   (hitSelect),
        .acqFinish   (acqFinish),
        .resultValid (resultValid),
        .resultReady (resultReady),
        .thMinus     (thMinus),
        .thPlus      (thPlus),
        .delta       (delta),
        .peakCh      (peakCh),
        .peakFh      (peakFh)
    );

    // 10 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic checkPos(input string what, input binAddrT got, input binAddrT exp);
        if (got !== exp) begin
            errorCount++;
            $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic checkFlag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errorCount++;
            $display("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic checkCycles(input string what, input int got, input int exp);
        if (got != exp) begin
            errorCount++;
            $display("FAILED at %0t ns: %s is %0d cycles, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic clearModel();
        for (int b = 0; b <= NumBins; b++) begin
            chRef[b] = 0;
            fhRef[b] = 0;
        end
    endtask

    // first bin with the highest count
    function automatic int findPeak(input int hist [0:NumBins]);
        int best;
        best = 1;
        for (int b = 2; b <= NumBins; b++) begin
            if (hist[b] > hist[best]) begin
                best = b;
            end
        end
        return best;
    endfunction

    task automatic sendHit(input int addr, input int sel);
        int waited;
        waited = 0;
        while (hitReady !== 1'b1 && waited < WaitLimit) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (hitReady !== 1'b1) begin
            timeoutCount++;
            $display("hit to bin %0d not sent, hitReady never came high", addr);
        end else begin
            hitValid = 1'b1;
            hitAddr = binAddrT'(addr);
            hitSelect = histSelT'(sel);
            @(posedge clk);
            #1;
            hitValid = 1'b0;
            // bin 0 does not exist, counters stop at the maximum
            if (addr >= 1 && addr <= NumBins) begin
                if (sel[0] && chRef[addr] < int'(CountMax)) begin
                    chRef[addr]++;
                end
                if (sel[1] && fhRef[addr] < int'(CountMax)) begin
                    fhRef[addr]++;
                end
            end
        end
    endtask

    task automatic finishAcq();
        acqFinish = 1'b1;
        @(posedge clk);
        #1;
        acqFinish = 1'b0;
    endtask

    // call right after finishAcq, latency counts from there
    task automatic collectResult(input int holdCycles);
        int edges;
        int pc;
        int pf;
        int d;
        int expMinus;
        int expPlus;
        binAddrT keepMinus;
        binAddrT keepPlus;
        binAddrT keepDelta;
        edges = 0;
        while (resultValid !== 1'b1 && edges < WaitLimit) begin
            @(posedge clk);
            #1;
            edges++;
        end
        if (resultValid !== 1'b1) begin
            timeoutCount++;
            $display("no result, resultValid stayed low for %0d cycles", WaitLimit);
        end else begin
            checkCycles("result latency", edges, ResultLatency);
            // expected window from the reference histograms
            pc = findPeak(chRef);
            pf = findPeak(fhRef);
            d = (pc > pf) ? pc - pf : pf - pc;
            if (d < 1) begin
                d = 1;
            end
            expMinus = (pc - d < 1) ? 1 : pc - d;
            expPlus = (pc + d > NumBins) ? NumBins : pc + d;
            checkPos("peakCh", peakCh, binAddrT'(pc));
            checkPos("peakFh", peakFh, binAddrT'(pf));
            checkPos("delta", delta, binAddrT'(d));
            checkPos("thMinus", thMinus, binAddrT'(expMinus));
            checkPos("thPlus", thPlus, binAddrT'(expPlus));
            checkFlag("hitReady while result waits", hitReady, 1'b0);
            keepMinus = thMinus;
            keepPlus = thPlus;
            keepDelta = delta;
            // back-pressure, nothing may move
            for (int i = 0; i < holdCycles; i++) begin
                @(posedge clk);
                #1;
                checkFlag("resultValid under back-pressure", resultValid, 1'b1);
                checkFlag("hitReady under back-pressure", hitReady, 1'b0);
                checkPos("thMinus under back-pressure", thMinus, keepMinus);
                checkPos("thPlus under back-pressure", thPlus, keepPlus);
                checkPos("delta under back-pressure", delta, keepDelta);
            end
            resultReady = 1'b1;
            @(posedge clk);
            #1;
            resultReady = 1'b0;
            checkFlag("resultValid after transfer", resultValid, 1'b0);
            checkFlag("hitReady after transfer", hitReady, 1'b1);
        end
        // the DUT clears its banks on the transfer
        clearModel();
    endtask

    // no real hits, only bin 0, gives peaks 1 and 1
    task automatic testEmpty();
        checkFlag("hitReady after reset", hitReady, 1'b1);
        checkFlag("resultValid after reset", resultValid, 1'b0);
        for (int i = 0; i < 4; i++) begin
            sendHit(0, 3);
        end
        finishAcq();
        collectResult(0);
    endtask

    task automatic testWeighted();
        int addr;
        int sel;
        for (int i = 0; i < 6; i++) begin
            sendHit(5, 1);
        end
        for (int i = 0; i < 7; i++) begin
            sendHit(11, 2);
        end
        for (int i = 0; i < 4; i++) begin
            sendHit(8, 3);
        end
        // random background
        for (int i = 0; i < 20; i++) begin
            addr = 1 + int'($unsigned($random(seed)) % NumBins);
            sel = 1 + int'($unsigned($random(seed)) % 3);
            sendHit(addr, sel);
        end
        finishAcq();
        collectResult(0);
    endtask

    // coarse peak near bin 1, fine peak on the last bin
    // lower edge clips to 1, upper edge lands on NumBins
    task automatic testClipping();
        for (int i = 0; i < 5; i++) begin
            sendHit(2, 1);
            sendHit(16, 2);
        end
        finishAcq();
        collectResult(0);
    endtask

    // equal counts, lower address expected
    task automatic testTie();
        for (int i = 0; i < 3; i++) begin
            sendHit(9, 3);
        end
        for (int i = 0; i < 3; i++) begin
            sendHit(4, 3);
        end
        finishAcq();
        collectResult(0);
    endtask

    task automatic testSaturation();
        for (int i = 0; i < 300; i++) begin
            sendHit(12, 3);
        end
        for (int i = 0; i < 256; i++) begin
            sendHit(7, 3);
        end
        for (int i = 0; i < 10; i++) begin
            sendHit(0, 3);
        end
        finishAcq();
        collectResult(0);
    endtask

    // held result, then a fresh acquisition on cleared banks
    task automatic testBackPressure();
        int holdCycles;
        holdCycles = 3 + int'($unsigned($random(seed)) % 16);
        for (int i = 0; i < 4; i++) begin
            sendHit(14, 1);
            sendHit(3, 2);
        end
        finishAcq();
        collectResult(holdCycles);
        for (int i = 0; i < 2; i++) begin
            sendHit(6, 3);
        end
        finishAcq();
        collectResult(0);
    endtask

    initial begin
        errorCount = 0;
        timeoutCount = 0;
        seed = 32'hf083_c284;
        reset = 1'b1;
        hitValid = 1'b0;
        hitAddr = '0;
        hitSelect = '0;
        acqFinish = 1'b0;
        resultReady = 1'b0;
        clearModel();
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        testEmpty();
        testWeighted();
        testClipping();
        testTie();
        testSaturation();
        testBackPressure();
        $display("errors: %0d wrong values, %0d timeouts", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- source/siFhTop.sv
`timescale 1ns/10ps

module siFhTop import siFhPkg::*; (
    input  logic    clk,
    input  logic    reset,
    // hit stream
    input  logic    hitValid,
    output logic    hitReady,
    input  binAddrT hitAddr,
    input  histSelT hitSelect,
    input  logic    acqFinish,
    // window result
    output logic    resultValid,
    input  logic    resultReady,
    output binAddrT thMinus,
    output binAddrT thPlus,
    output binAddrT delta,
    // peak positions behind the window
    output binAddrT peakCh,
    output binAddrT peakFh
);

    // builder to detector stream
    logic     binValid;
    binAddrT  binAddr;
    binCountT chCount;
    binCountT fhCount;
    logic     binLast;

    // detector to calculator
    logic peakValid;

    // calculator back to builder
    logic resultDone;

    histogramBuilder histogramBuilder0 (
        .clk        (clk),
        .reset      (reset),
        .hitValid   (hitValid),
        .hitReady   (hitReady),
        .hitAddr    (hitAddr),
        .hitSelect  (hitSelect),
        .acqFinish  (acqFinish),
        .resultDone (resultDone),
        .binValid   (binValid),
        .binAddr    (binAddr),
        .chCount    (chCount),
        .fhCount    (fhCount),
        .binLast    (binLast)
    );

    // peaks stay put from binLast until the next readout
    peakDetector peakDetector0 (
        .clk       (clk),
        .reset     (reset),
        .binValid  (binValid),
        .binAddr   (binAddr),
        .chCount   (chCount),
        .fhCount   (fhCount),
        .binLast   (binLast),
        .peakValid (peakValid),
        .peakCh    (peakCh),
        .peakFh    (peakFh)
    );

    thresholdCalculator thresholdCalculator0 (
        .clk         (clk),
        .reset       (reset),
        .peakValid   (peakValid),
        .peakCh      (peakCh),
        .peakFh      (peakFh),
        .resultValid (resultValid),
        .resultReady (resultReady),
        .thMinus     (thMinus),
        .thPlus      (thPlus),
        .delta       (delta),
        .resultDone  (resultDone)
    );

endmodule

//--- source/thresholdCalculator.sv
`timescale 1ns/10ps

module thresholdCalculator import siFhPkg::*; (
    input  logic    clk,
    input  logic    reset,
    // peaks from the detector
    input  logic    peakValid,
    input  binAddrT peakCh,
    input  binAddrT peakFh,
    // result interface
    output logic    resultValid,
    input  logic    resultReady,
    output binAddrT thMinus,
    output binAddrT thPlus,
    output binAddrT delta,
    // transfer pulse back to the builder
    output logic    resultDone
);

    binAddrT distance;
    binAddrT deltaNext;
    binAddrT minusNext;
    binAddrT plusNext;

    // one bit wider, coarse peak plus delta
    logic [BinWidth:0] plusWide;

    always_comb begin
        // distance between coarse and fine peak
        if (peakCh >= peakFh) begin
            distance = peakCh - peakFh;
        end else begin
            distance = peakFh - peakCh;
        end

        // half-width never below one bin
        deltaNext = (distance == '0) ? FirstBin : distance;

        // lower edge, clipped to bin 1
        if (peakCh <= deltaNext) begin
            minusNext = FirstBin;
        end else begin
            minusNext = peakCh - deltaNext;
        end

        // upper edge, clipped to the last bin
        plusWide = {1'b0, peakCh} + {1'b0, deltaNext};
        if (plusWide > {1'b0, LastBin}) begin
            plusNext = LastBin;
        end else begin
            plusNext = plusWide[BinWidth-1:0];
        end
    end

    // transfer happens this cycle
    assign resultDone = resultValid && resultReady;

    // valid held until taken
    always_ff @(posedge clk) begin
        if (reset) begin
            resultValid <= 1'b0;
        end else if (peakValid) begin
            resultValid <= 1'b1;
        end else if (resultDone) begin
            resultValid <= 1'b0;
        end
    end

    // window data, loaded once per readout
    always_ff @(posedge clk) begin
        if (peakValid) begin
            delta <= deltaNext;
            thMinus <= minusNext;
            thPlus <= plusNext;
        end
    end

    // result held steady under back-pressure
    assertResultStable: assert property (
        @(posedge clk) disable iff (reset)
        resultValid && !resultReady |=>
            resultValid && $stable(delta) && $stable(thMinus) && $stable(thPlus)
    );

endmodule

//--- source/peakDetector.sv
`timescale 1ns/10ps

module peakDetector import siFhPkg::*; (
    input  logic     clk,
    input  logic     reset,
    // readout stream, one bin per cycle
    input  logic     binValid,
    input  binAddrT  binAddr,
    input  binCountT chCount,
    input  binCountT fhCount,
    input  logic     binLast,
    // final peaks, pulse one cycle after binLast
    output logic     peakValid,
    output binAddrT  peakCh,
    output binAddrT  peakFh
);

    // running maximum and where it sits
    binCountT maxCh;
    binCountT maxFh;
    binAddrT  maxChAddr;
    binAddrT  maxFhAddr;

    // maximum including the bin on the stream now
    binCountT nextMaxCh;
    binCountT nextMaxFh;
    binAddrT  nextChAddr;
    binAddrT  nextFhAddr;

    // compare current bin against the running max
    // bin 1 always seeds, strict compare keeps the lowest address on ties
    always_comb begin
        if ((binAddr == FirstBin) || (chCount > maxCh)) begin
            nextMaxCh = chCount;
            nextChAddr = binAddr;
        end else begin
            nextMaxCh = maxCh;
            nextChAddr = maxChAddr;
        end

        if ((binAddr == FirstBin) || (fhCount > maxFh)) begin
            nextMaxFh = fhCount;
            nextFhAddr = binAddr;
        end else begin
            nextMaxFh = maxFh;
            nextFhAddr = maxFhAddr;
        end
    end

    // track the maximum while bins stream past
    always_ff @(posedge clk) begin
        if (binValid) begin
            maxCh <= nextMaxCh;
            maxFh <= nextMaxFh;
            maxChAddr <= nextChAddr;
            maxFhAddr <= nextFhAddr;
        end
    end

    // final peaks captured with the last bin
    // held until the next readout, so stable while the result waits
    always_ff @(posedge clk) begin
        if (binValid && binLast) begin
            peakCh <= nextChAddr;
            peakFh <= nextFhAddr;
        end
    end

    // one-cycle completion pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            peakValid <= 1'b0;
        end else begin
            peakValid <= binValid && binLast;
        end
    end

endmodule

//--- source/histogramBuilder.sv
`timescale 1ns/10ps

module histogramBuilder import siFhPkg::*; (
    input  logic     clk,
    input  logic     reset,
    // hit stream
    input  logic     hitValid,
    output logic     hitReady,
    input  binAddrT  hitAddr,
    input  histSelT  hitSelect,
    // end of acquisition, single-cycle
    input  logic     acqFinish,
    // result taken downstream, clears both banks
    input  logic     resultDone,
    // readout stream to the peak detector
    output logic     binValid,
    output binAddrT  binAddr,
    output binCountT chCount,
    output binCountT fhCount,
    output logic     binLast
);

    // coarse and fine counter banks, entry i holds bin i+1
    binCountT chBank [0:NumBins-1];
    binCountT fhBank [0:NumBins-1];

    builderStateT state;

    // readout pointer, walks 1..NumBins
    binAddrT readPtr;

    logic hitTake;
    logic hitInRange;
    logic clearBanks;
    logic [BinIdxWidth-1:0] hitIdx;
    logic [BinIdxWidth-1:0] readIdx;

    // hits only while accumulating
    assign hitReady = (state == Accumulate);
    assign hitTake = hitValid && hitReady;

    // address 0 and anything above the last bin is dropped
    assign hitInRange = (hitAddr != '0) && (hitAddr <= LastBin);

    // bank index, address minus one
    assign hitIdx = BinIdxWidth'(hitAddr - FirstBin);
    assign readIdx = BinIdxWidth'(readPtr - FirstBin);

    // counters clear on the result transfer edge
    assign clearBanks = (state == Hold) && resultDone;

    // counter banks
    // the hit taken on the acqFinish edge still counts,
    // readout starts reading one cycle later
    always_ff @(posedge clk) begin
        if (reset || clearBanks) begin
            for (int i = 0; i < NumBins; i++) begin
                chBank[i] <= '0;
                fhBank[i] <= '0;
            end
        end else if (hitTake && hitInRange) begin
            // coarse bank, saturating
            if (hitSelect[0] && (chBank[hitIdx] != CountMax)) begin
                chBank[hitIdx] <= chBank[hitIdx] + 1'b1;
            end
            // fine bank, saturating
            if (hitSelect[1] && (fhBank[hitIdx] != CountMax)) begin
                fhBank[hitIdx] <= fhBank[hitIdx] + 1'b1;
            end
        end
    end

    // acquisition / readout / hold sequencing
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= Accumulate;
            readPtr <= FirstBin;
        end else begin
            case (state)
                Accumulate: begin
                    // acqFinish only looked at here
                    if (acqFinish) begin
                        state <= Readout;
                        readPtr <= FirstBin;
                    end
                end
                Readout: begin
                    // one bin per cycle, no stall
                    if (readPtr == LastBin) begin
                        state <= Hold;
                    end else begin
                        readPtr <= readPtr + 1'b1;
                    end
                end
                Hold: begin
                    // back to counting once the window is taken
                    if (resultDone) begin
                        state <= Accumulate;
                    end
                end
                default: begin
                    state <= Accumulate;
                end
            endcase
        end
    end

    // readout stream straight from the banks
    assign binValid = (state == Readout);
    assign binAddr = readPtr;
    assign chCount = chBank[readIdx];
    assign fhCount = fhBank[readIdx];
    assign binLast = binValid && (readPtr == LastBin);

    // a full coarse counter stays full when hit again, no wrap
    assertChSaturate: assert property (
        @(posedge clk) disable iff (reset)
        hitTake && hitInRange && hitSelect[0] && (chBank[hitIdx] == CountMax)
            |=> (chBank[$past(hitIdx)] == CountMax)
    );

    // same for the fine bank
    assertFhSaturate: assert property (
        @(posedge clk) disable iff (reset)
        hitTake && hitInRange && hitSelect[1] && (fhBank[hitIdx] == CountMax)
            |=> (fhBank[$past(hitIdx)] == CountMax)
    );

    // streamed address stays inside the real bins
    assertBinRange: assert property (
        @(posedge clk) disable iff (reset)
        binValid |-> (binAddr >= FirstBin) && (binAddr <= LastBin)
    );

endmodule

//--- source/siFhPkg.sv
package siFhPkg;

    // histogram geometry
    // bins are addressed 1..NumBins, address 0 means no bin
    localparam int NumBins = 16;

    // one extra bit so that NumBins itself is representable
    localparam int BinWidth = 5;

    // index into a counter bank, address minus one
    localparam int BinIdxWidth = $clog2(NumBins);

    // per-bin counter width
    localparam int CountWidth = 8;

    // bin address, peak position or threshold position
    typedef logic [BinWidth-1:0] binAddrT;

    // content of one histogram bin
    typedef logic [CountWidth-1:0] binCountT;

    // bit 0 counts into the coarse histogram, bit 1 into the fine one
    typedef logic [1:0] histSelT;

    // first and last valid bin address
    localparam binAddrT FirstBin = binAddrT'(1);
    localparam binAddrT LastBin = binAddrT'(NumBins);

    // counters stop here instead of wrapping
    localparam binCountT CountMax = binCountT'(255);

    // builder sequencing
    // Accumulate takes hits, Readout streams the bins out,
    // Hold waits for the result to be taken
    typedef enum logic [1:0] {
        Accumulate,
        Readout,
        Hold
    } builderStateT;

endpackage
